/* list.f */
+incdir+.
rv_isa_pkg.sv
rv_core_pkg.sv
inst_cycle_ctrl.sv
if_stage.sv
regfile.sv
id_stage.sv
exe_stage.sv
rv_core_top.sv
tb_rv_core.sv

/* tb_rv_core.sv */
// assumes a program of at most 256 words at RV_PC_RESET and a one-cycle fetch memory; no data memory
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module tb_rv_core;

  localparam int MEM_WORDS = 256;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;

  logic        clk;
  logic        rst_n_i;
  logic [31:0] inst_i;
  logic        inst_ena_o;
  logic [63:0] inst_addr_o;
  logic        wb_en_o;
  logic [4:0]  wb_rd_o;
  logic [63:0] wb_data_o;

  logic [31:0] mem [MEM_WORDS];
  string       names [MEM_WORDS]; // test name per instruction slot
  logic [63:0] ref_regs [32];
  int          prog_len;
  logic        fetch_req;
  logic [63:0] fetch_addr;

  rv_core_top i_dut (
    .clk(clk), .rst_n_i(rst_n_i), .inst_i(inst_i), .inst_ena_o(inst_ena_o),
    .inst_addr_o(inst_addr_o), .wb_en_o(wb_en_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // instruction memory, answers in the cycle after the request
  always begin
    @(negedge clk);
    fetch_req  = inst_ena_o;
    fetch_addr = inst_addr_o;
    @(posedge clk);
    #1;
    if (fetch_req) begin
      inst_i = mem[fetch_addr[9:2]];
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [4:0] pick_src();
    return 5'($urandom_range(4, 1));
  endfunction

  // shift forms carry shamt plus the arithmetic bit, other forms a random immediate
  function automatic logic [11:0] alu_imm(input int f3, input int alt, input int shw);
    logic [11:0] imm;
    imm = 12'($urandom);
    if (f3 == 1 || f3 == 5) begin
      imm = {1'b0, alt[0], 10'b0} | (imm & 12'((1 << shw) - 1));
    end
    return imm;
  endfunction

  function automatic logic [63:0] alu64(input logic [2:0] f3, input logic alt,
      input logic [63:0] a, input logic [63:0] b);
    logic [63:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[5:0];
      3'd2: r = {63'b0, $signed(a) < $signed(b)};
      3'd3: r = {63'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[5:0];
        else r = a >> b[5:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic [63:0] alu32(input logic [2:0] f3, input logic alt,
      input logic [63:0] a, input logic [63:0] b);
    logic [31:0] r;
    r = '0;
    if (f3 == 3'd0) r = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
    if (f3 == 3'd1) r = a[31:0] << b[4:0];
    if (f3 == 3'd5 && alt) r = $signed(a[31:0]) >>> b[4:0];
    if (f3 == 3'd5 && !alt) r = a[31:0] >> b[4:0];
    return {{32{r[31]}}, r};
  endfunction

  // RV64I rules for the write-back and the next pc
  task automatic predict(input logic [31:0] w, input logic [63:0] pc, output logic wen,
      output logic [63:0] data, output logic [63:0] npc);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] immi;
    logic [63:0] immu;
    logic [63:0] immb;
    logic [63:0] immj;
    logic        alt;
    logic        take;
    a    = ref_regs[w[19:15]];
    b    = ref_regs[w[24:20]];
    immi = $signed(w[31:20]);
    immu = $signed({w[31:12], 12'h000});
    immb = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
    immj = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
    alt  = w[30] && (w[5] || w[14:12] == 3'd5); // bit 5 marks the register groups
    wen  = 1'b1;
    data = '0;
    npc  = pc + 64'd4;
    case (w[6:0])
      OPC_LUI:   data = immu;
      OPC_AUIPC: data = pc + immu;
      OPC_JAL: begin
        data = pc + 64'd4;
        npc  = pc + immj;
      end
      OPC_JALR: begin
        data = pc + 64'd4;
        npc  = (a + immi) & ~64'd1;
      end
      OPC_BRANCH: begin
        wen = 1'b0;
        case (w[14:12])
          3'd0: take = (a == b);
          3'd1: take = (a != b);
          3'd4: take = ($signed(a) < $signed(b));
          3'd5: take = ($signed(a) >= $signed(b));
          3'd6: take = (a < b);
          3'd7: take = (a >= b);
          default: take = 1'b0;
        endcase
        if (take) npc = pc + immb;
      end
      OPC_OP_IMM:    data = alu64(w[14:12], alt, a, immi);
      OPC_OP:        data = alu64(w[14:12], alt, a, b);
      OPC_OP_IMM_32: data = alu32(w[14:12], alt, a, immi);
      OPC_OP_32:     data = alu32(w[14:12], alt, a, b);
      default: wen = 1'b0;
    endcase
  endtask

  task automatic emit(input string name, input logic [31:0] word);
    mem[prog_len]   = word;
    names[prog_len] = name;
    prog_len++;
  endtask

  task automatic emit_alu_round();
    logic [4:0] rd;
    for (int f3 = 0; f3 < 8; f3++) begin
      for (int alt = 0; alt < 2; alt++) begin
        rd = 5'(5 + prog_len % 5);
        if (alt == 0 || f3 == 0 || f3 == 5) begin
          emit("alu_op", enc_r({1'b0, alt[0], 5'b0}, pick_src(), pick_src(), 3'(f3), rd, OPC_OP));
        end
        if (alt == 0 || f3 == 5) begin
          emit("alu_op_imm", enc_i(alu_imm(f3, alt, 6), pick_src(), 3'(f3), rd, OPC_OP_IMM));
        end
        if ((f3 == 0 || f3 == 1 || f3 == 5) && (alt == 0 || f3 != 1)) begin
          emit("alu_op_32", enc_r({1'b0, alt[0], 5'b0}, pick_src(), pick_src(), 3'(f3), rd,
                                  OPC_OP_32));
        end
        if ((f3 == 0 || f3 == 1 || f3 == 5) && (alt == 0 || f3 == 5)) begin
          emit("alu_op_imm_32", enc_i(alu_imm(f3, alt, 5), pick_src(), 3'(f3), rd, OPC_OP_IMM_32));
        end
      end
    end
  endtask

  task automatic build_program();
    logic [31:0] hi;
    int          tgt;
    int          bf3 [6] = '{0, 1, 4, 5, 6, 7};
    int          b1 [3]  = '{10, 11, 11};
    int          b2 [3]  = '{11, 10, 12};
    for (int r = 1; r <= 4; r++) begin
      hi = $urandom;
      emit("load", enc_u(hi[19:0], 5'(r), OPC_LUI));
      emit("load", enc_i(hi[31:20], 5'(r), 3'd0, 5'(r), OPC_OP_IMM));
    end
    emit("load", enc_i(12'd32, 5'd3, 3'd1, 5'd3, OPC_OP_IMM)); // x3 gets a full 64-bit value
    emit("load", enc_r(7'd0, 5'd1, 5'd3, 3'd4, 5'd3, OPC_OP));
    repeat (2) emit_alu_round();
    emit("x0", enc_i(12'h123, 5'd1, 3'd0, 5'd0, OPC_OP_IMM));
    emit("x0", enc_r(7'd0, 5'd2, 5'd0, 3'd0, 5'd6, OPC_OP));
    emit("x0", enc_r(7'h20, 5'd0, 5'd1, 3'd0, 5'd7, OPC_OP));
    emit("branch", enc_i(12'hffb, 5'd0, 3'd0, 5'd10, OPC_OP_IMM)); // -5, negative for bgeu
    emit("branch", enc_i(12'd7, 5'd0, 3'd0, 5'd11, OPC_OP_IMM));
    emit("branch", enc_i(12'd7, 5'd0, 3'd0, 5'd12, OPC_OP_IMM));
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        emit("branch", enc_b(13'd8, 5'(b2[p]), 5'(b1[p]), 3'(bf3[c])));
        emit("branch_skip", enc_i(12'd1, 5'd20, 3'd0, 5'd20, OPC_OP_IMM));
      end
    end
    emit("jal", enc_j(21'd8, 5'd13));
    emit("jal_skip", enc_i(12'd1, 5'd20, 3'd0, 5'd20, OPC_OP_IMM));
    tgt = (prog_len + 3) * 4 + 1; // odd target
    emit("jalr", enc_i(12'(tgt), 5'd0, 3'd0, 5'd15, OPC_OP_IMM));
    emit("jalr", enc_i(12'd0, 5'd15, 3'd0, 5'd16, OPC_JALR));
    emit("jalr_skip", enc_i(12'd1, 5'd20, 3'd0, 5'd20, OPC_OP_IMM));
    hi = $urandom;
    emit("lui", enc_u(hi[19:0], 5'd17, OPC_LUI));
    emit("auipc", enc_u(hi[31:12], 5'd18, OPC_AUIPC));
    emit("unsupported", {7'd0, 5'd1, 5'd0, 3'b011, 5'd8, 7'b0100011}); // sd
    emit("unsupported", enc_i(12'd1, 5'd0, 3'd0, 5'd21, OPC_OP_IMM));
  endtask

  task automatic wait_fetch(output int waited);
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!inst_ena_o && waited < 4 * `RV_INST_CYCLES);
    assert (inst_ena_o) else stop_on_error("no fetch request before the timeout");
  endtask

  task automatic run_program();
    logic [63:0] pc;
    logic [31:0] w;
    logic        exp_wen;
    logic [63:0] exp_data;
    logic [63:0] npc;
    int          waited;
    bit          first;
    string       tn;
    pc    = `RV_PC_RESET;
    first = 1'b1;
    while (pc < 64'(prog_len) * 64'd4) begin
      wait_fetch(waited);
      tn = names[pc[9:2]];
      if (!first) begin
        assert (waited + `RV_INST_CYCLES - 1 == `RV_INST_CYCLES) else
          stop_on_error($sformatf("fetch before %s was not %0d cycles after the previous one",
                                  tn, `RV_INST_CYCLES));
      end
      first = 1'b0;
      assert (inst_addr_o == pc) else
        stop_on_error($sformatf("Mismatch %s addr expected %0h actual %0h", tn, pc, inst_addr_o));
      w = mem[pc[9:2]];
      predict(w, pc, exp_wen, exp_data, npc);
      for (int k = 1; k < `RV_INST_CYCLES; k++) begin
        @(negedge clk);
        assert (!inst_ena_o) else stop_on_error($sformatf("extra fetch request during %s", tn));
        if (k == `RV_EXE_STEP) begin
          assert (wb_en_o == exp_wen) else
            stop_on_error($sformatf("Mismatch %s wb_en expected %0d actual %0d",
                                    tn, exp_wen, wb_en_o));
          if (exp_wen) begin
            assert (wb_rd_o == w[11:7]) else
              stop_on_error($sformatf("Mismatch %s rd expected %0d actual %0d",
                                      tn, w[11:7], wb_rd_o));
            assert (wb_data_o == exp_data) else
              stop_on_error($sformatf("Mismatch %s data expected %0h actual %0h",
                                      tn, exp_data, wb_data_o));
          end
        end else begin
          assert (!wb_en_o) else stop_on_error($sformatf("write-back outside step 4 in %s", tn));
        end
      end
      if (exp_wen && w[11:7] != 5'd0) ref_regs[w[11:7]] = exp_data;
      pc = npc;
    end
  endtask

  initial begin
    void'($urandom(32'h4b48));
    rst_n_i  = 1'b0;
    inst_i   = '0;
    prog_len = 0;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = {4'h0, 8'(i), 13'h0, 7'b0100011};
    build_program();
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #1;
      assert (!inst_ena_o && !wb_en_o) else stop_on_error("fetch or write-back active in reset");
    end
    rst_n_i = 1'b1;
    run_program();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* rv_core_top.sv */
// one instruction every six cycles; fetch memory must answer in one cycle, no data memory
`timescale 1ns/10ps
`default_nettype none

module rv_core_top (
  input  wire                       clk,
  input  wire                       rst_n_i,
  input  wire rv_isa_pkg::inst_t    inst_i,
  output logic                      inst_ena_o,
  output rv_core_pkg::xlen_t        inst_addr_o,
  output logic                      wb_en_o,
  output rv_core_pkg::reg_idx_t     wb_rd_o,
  output rv_core_pkg::xlen_t        wb_data_o
);

  rv_core_pkg::inst_cycle_t cycle_cnt;
  rv_core_pkg::xlen_t       pc;
  rv_isa_pkg::inst_t        inst;
  logic                     pc_jmp;
  rv_core_pkg::xlen_t       pc_jmpaddr;
  rv_core_pkg::reg_idx_t    rs1;
  rv_core_pkg::reg_idx_t    rs2;
  rv_core_pkg::reg_idx_t    rd;
  rv_core_pkg::xlen_t       rs1_data;
  rv_core_pkg::xlen_t       rs2_data;
  rv_isa_pkg::opcode_e      opcode;
  rv_isa_pkg::funct3_t      funct3;
  rv_isa_pkg::funct7_t      funct7;
  rv_core_pkg::xlen_t       op1;
  rv_core_pkg::xlen_t       op2;
  rv_core_pkg::xlen_t       t1;
  logic                     rd_wen;
  rv_core_pkg::xlen_t       rd_data;

  inst_cycle_ctrl u_cycle (.clk(clk), .rst_n_i(rst_n_i), .cycle_cnt_o(cycle_cnt));

  if_stage u_if (
    .clk(clk), .rst_n_i(rst_n_i), .cycle_cnt_i(cycle_cnt),
    .pc_jmp_i(pc_jmp), .pc_jmpaddr_i(pc_jmpaddr), .inst_i(inst_i),
    .inst_ena_o(inst_ena_o), .inst_addr_o(inst_addr_o), .pc_o(pc), .inst_o(inst)
  );

  regfile u_rf (
    .clk(clk), .rst_n_i(rst_n_i), .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd),
    .wen_i(rd_wen), .wdata_i(rd_data), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  id_stage u_id (
    .clk(clk), .rst_n_i(rst_n_i), .cycle_cnt_i(cycle_cnt), .inst_i(inst), .pc_i(pc),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd),
    .opcode_o(opcode), .funct3_o(funct3), .funct7_o(funct7),
    .op1_o(op1), .op2_o(op2), .t1_o(t1)
  );

  exe_stage u_exe (
    .clk(clk), .rst_n_i(rst_n_i), .cycle_cnt_i(cycle_cnt),
    .opcode_i(opcode), .funct3_i(funct3), .funct7_i(funct7),
    .op1_i(op1), .op2_i(op2), .t1_i(t1), .rd_wen_o(rd_wen), .rd_data_o(rd_data),
    .pc_jmp_o(pc_jmp), .pc_jmpaddr_o(pc_jmpaddr)
  );

  // write-back trace, same pulse as the regfile write
  assign wb_en_o   = rd_wen;
  assign wb_rd_o   = rd;
  assign wb_data_o = rd_data;

endmodule

`default_nettype wire

/* exe_stage.sv */
// result valid only at RV_EXE_STEP; jump decision registered for the pc update in the next step
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module exe_stage (
  input  wire                           clk,
  input  wire                           rst_n_i,
  input  wire rv_core_pkg::inst_cycle_t cycle_cnt_i,
  input  wire rv_isa_pkg::opcode_e      opcode_i,
  input  wire rv_isa_pkg::funct3_t      funct3_i,
  input  wire rv_isa_pkg::funct7_t      funct7_i,
  input  wire rv_core_pkg::xlen_t       op1_i,
  input  wire rv_core_pkg::xlen_t       op2_i,
  input  wire rv_core_pkg::xlen_t       t1_i,
  output logic                          rd_wen_o,
  output rv_core_pkg::xlen_t            rd_data_o,
  output logic                          pc_jmp_o,
  output rv_core_pkg::xlen_t            pc_jmpaddr_o
);

  logic               ex_active;
  logic               alt_op;
  logic               sub_op;
  logic [5:0]         shamt;
  logic [4:0]         shamt_w;
  rv_core_pkg::xlen_t alu_res;
  logic [31:0]        alu_w;    // W form result before sign extension
  logic               br_take;
  logic               jmp_take;
  rv_core_pkg::xlen_t jmp_target;

  assign ex_active = (cycle_cnt_i == `RV_EXE_STEP);
  assign alt_op    = funct7_i[rv_isa_pkg::F7_ALT_BIT];
  assign sub_op    = alt_op & ((opcode_i == rv_isa_pkg::OP) | (opcode_i == rv_isa_pkg::OP_32));
  assign shamt     = op2_i[5:0];
  assign shamt_w   = op2_i[4:0];

  always_comb begin
    alu_res = '0;
    case (funct3_i)
      rv_isa_pkg::F3_ADD:  alu_res = sub_op ? op1_i - op2_i : op1_i + op2_i;
      rv_isa_pkg::F3_SLL:  alu_res = op1_i << shamt;
      rv_isa_pkg::F3_SLT:  alu_res = rv_core_pkg::xlen_t'($signed(op1_i) < $signed(op2_i));
      rv_isa_pkg::F3_SLTU: alu_res = rv_core_pkg::xlen_t'(op1_i < op2_i);
      rv_isa_pkg::F3_XOR:  alu_res = op1_i ^ op2_i;
      rv_isa_pkg::F3_SR: begin
        if (alt_op) begin
          alu_res = $signed(op1_i) >>> shamt;
        end else begin
          alu_res = op1_i >> shamt;
        end
      end
      rv_isa_pkg::F3_OR:   alu_res = op1_i | op2_i;
      rv_isa_pkg::F3_AND:  alu_res = op1_i & op2_i;
      default: ;
    endcase
  end

  // 32-bit forms
  always_comb begin
    alu_w = '0;
    case (funct3_i)
      rv_isa_pkg::F3_ADD: alu_w = sub_op ? op1_i[31:0] - op2_i[31:0] : op1_i[31:0] + op2_i[31:0];
      rv_isa_pkg::F3_SLL: alu_w = op1_i[31:0] << shamt_w;
      rv_isa_pkg::F3_SR: begin
        if (alt_op) begin
          alu_w = $signed(op1_i[31:0]) >>> shamt_w;
        end else begin
          alu_w = op1_i[31:0] >> shamt_w;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    rd_wen_o  = 1'b0;
    rd_data_o = '0;
    if (ex_active) begin
      rd_wen_o = 1'b1;
      case (opcode_i)
        rv_isa_pkg::LUI:   rd_data_o = op1_i;
        rv_isa_pkg::AUIPC: rd_data_o = op1_i + op2_i;
        rv_isa_pkg::JAL:   rd_data_o = op1_i;
        rv_isa_pkg::JALR:  rd_data_o = t1_i;
        rv_isa_pkg::OP, rv_isa_pkg::OP_IMM: rd_data_o = alu_res;
        rv_isa_pkg::OP_32, rv_isa_pkg::OP_IMM_32: begin
          rd_data_o = {{(`RV_XLEN-32){alu_w[31]}}, alu_w};
        end
        default: rd_wen_o = 1'b0; // branches and unknown opcodes
      endcase
    end
  end

  always_comb begin
    case (funct3_i)
      rv_isa_pkg::F3_BEQ:  br_take = (op1_i == op2_i);
      rv_isa_pkg::F3_BNE:  br_take = (op1_i != op2_i);
      rv_isa_pkg::F3_BLT:  br_take = ($signed(op1_i) < $signed(op2_i));
      rv_isa_pkg::F3_BGE:  br_take = ($signed(op1_i) >= $signed(op2_i));
      rv_isa_pkg::F3_BLTU: br_take = (op1_i < op2_i);
      rv_isa_pkg::F3_BGEU: br_take = (op1_i >= op2_i);
      default:             br_take = 1'b0;
    endcase
  end

  assign jmp_take = (opcode_i == rv_isa_pkg::JAL) | (opcode_i == rv_isa_pkg::JALR) |
                    ((opcode_i == rv_isa_pkg::BRANCH) & br_take);

  always_comb begin
    case (opcode_i)
      rv_isa_pkg::JAL:  jmp_target = op2_i;
      rv_isa_pkg::JALR: jmp_target = (op1_i + op2_i) & ~rv_core_pkg::xlen_t'(1);
      default:          jmp_target = t1_i; // branch target
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_jmp_o <= 1'b0;
    end else begin
      pc_jmp_o <= ex_active & jmp_take;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_active) begin
      pc_jmpaddr_o <= jmp_target;
    end
  end

endmodule

`default_nettype wire

/* id_stage.sv */
// operands follow the op1/op2/t1 convention; unknown opcodes pass through with zero operands
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module id_stage (
  input  wire                           clk,
  input  wire                           rst_n_i,
  input  wire rv_core_pkg::inst_cycle_t cycle_cnt_i,
  input  wire rv_isa_pkg::inst_t        inst_i,
  input  wire rv_core_pkg::xlen_t       pc_i,
  input  wire rv_core_pkg::xlen_t       rs1_data_i,
  input  wire rv_core_pkg::xlen_t       rs2_data_i,
  output rv_core_pkg::reg_idx_t         rs1_o,
  output rv_core_pkg::reg_idx_t         rs2_o,
  output rv_core_pkg::reg_idx_t         rd_o,
  output rv_isa_pkg::opcode_e           opcode_o,
  output rv_isa_pkg::funct3_t           funct3_o,
  output rv_isa_pkg::funct7_t           funct7_o,
  output rv_core_pkg::xlen_t            op1_o,
  output rv_core_pkg::xlen_t            op2_o,
  output rv_core_pkg::xlen_t            t1_o
);

  localparam int DEC_STEP = `RV_EXE_STEP - 1;

  rv_isa_pkg::opcode_e opcode_d;
  rv_core_pkg::xlen_t  imm_itype;
  rv_core_pkg::xlen_t  imm_utype;
  rv_core_pkg::xlen_t  imm_jtype;
  rv_core_pkg::xlen_t  imm_btype;
  rv_core_pkg::xlen_t  pc_plus4;
  rv_core_pkg::xlen_t  op1_d;
  rv_core_pkg::xlen_t  op2_d;
  rv_core_pkg::xlen_t  t1_d;
  logic                dec_en;

  assign opcode_d = rv_isa_pkg::opcode_e'(inst_i[6:2]);
  assign rs1_o    = inst_i[19:15];
  assign rs2_o    = inst_i[24:20];
  assign pc_plus4 = pc_i + rv_core_pkg::xlen_t'(4);
  assign dec_en   = (cycle_cnt_i == DEC_STEP);

  // sign-extended immediates
  assign imm_itype = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_utype = {{(`RV_XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_jtype = {{(`RV_XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                      inst_i[20], inst_i[30:21], 1'b0};
  assign imm_btype = {{(`RV_XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                      inst_i[30:25], inst_i[11:8], 1'b0};

  always_comb begin
    op1_d = '0;
    op2_d = '0;
    t1_d  = '0;
    case (opcode_d)
      rv_isa_pkg::LUI: begin
        op1_d = imm_utype;
      end
      rv_isa_pkg::AUIPC: begin
        op1_d = pc_i;
        op2_d = imm_utype;
      end
      rv_isa_pkg::JAL: begin
        op1_d = pc_plus4; // link value
        op2_d = pc_i + imm_jtype;
      end
      rv_isa_pkg::JALR: begin
        op1_d = rs1_data_i;
        op2_d = imm_itype;
        t1_d  = pc_plus4;
      end
      rv_isa_pkg::BRANCH: begin
        op1_d = rs1_data_i;
        op2_d = rs2_data_i;
        t1_d  = pc_i + imm_btype;
      end
      rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_IMM_32: begin
        op1_d = rs1_data_i;
        op2_d = imm_itype; // shamt sits in the low bits
      end
      rv_isa_pkg::OP, rv_isa_pkg::OP_32: begin
        op1_d = rs1_data_i;
        op2_d = rs2_data_i;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      opcode_o <= rv_isa_pkg::opcode_e'(5'b0);
      funct3_o <= '0;
      funct7_o <= '0;
      rd_o     <= '0;
    end else if (dec_en) begin
      opcode_o <= opcode_d;
      funct3_o <= inst_i[14:12];
      funct7_o <= inst_i[31:25];
      rd_o     <= inst_i[11:7];
    end
  end

  // operands
  always_ff @(posedge clk) begin
    if (dec_en) begin
      op1_o <= op1_d;
      op2_o <= op2_d;
      t1_o  <= t1_d;
    end
  end

endmodule

`default_nettype wire

/* regfile.sv */
// x0 reads as zero and ignores writes; all registers clear on reset
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module regfile (
  input  wire                         clk,
  input  wire                         rst_n_i,
  input  wire rv_core_pkg::reg_idx_t  rs1_i,
  input  wire rv_core_pkg::reg_idx_t  rs2_i,
  input  wire rv_core_pkg::reg_idx_t  rd_i,
  input  wire                         wen_i,
  input  wire rv_core_pkg::xlen_t     wdata_i,
  output rv_core_pkg::xlen_t          rs1_data_o,
  output rv_core_pkg::xlen_t          rs2_data_o
);

  rv_core_pkg::xlen_t regs [`RV_REG_NUM];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `RV_REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (rd_i != '0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // combinational reads
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

/* if_stage.sv */
// memory must return inst_i in the cycle after inst_ena_o; no stall, pc moves only at the last step
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module if_stage (
  input  wire                       clk,
  input  wire                       rst_n_i,
  input  wire rv_core_pkg::inst_cycle_t cycle_cnt_i,
  input  wire                       pc_jmp_i,
  input  wire rv_core_pkg::xlen_t   pc_jmpaddr_i,
  input  wire rv_isa_pkg::inst_t    inst_i,
  output logic                      inst_ena_o,
  output rv_core_pkg::xlen_t        inst_addr_o,
  output rv_core_pkg::xlen_t        pc_o,
  output rv_isa_pkg::inst_t         inst_o
);

  localparam int CAPTURE_STEP = 1;
  localparam int PC_STEP      = `RV_INST_CYCLES - 1;

  logic               fetch_arm_q; // keeps the idle cycle after reset release quiet
  rv_core_pkg::xlen_t pc_q;
  rv_isa_pkg::inst_t  inst_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fetch_arm_q <= 1'b0;
      pc_q        <= `RV_PC_RESET;
    end else begin
      fetch_arm_q <= 1'b1;
      if (cycle_cnt_i == PC_STEP) begin
        pc_q <= pc_jmp_i ? pc_jmpaddr_i : pc_q + rv_core_pkg::xlen_t'(4);
      end
    end
  end

  // returned word
  always_ff @(posedge clk) begin
    if (cycle_cnt_i == CAPTURE_STEP) begin
      inst_q <= inst_i;
    end
  end

  assign inst_ena_o  = fetch_arm_q & (cycle_cnt_i == '0);
  assign inst_addr_o = pc_q;
  assign pc_o        = pc_q;
  assign inst_o      = inst_q;

endmodule

`default_nettype wire

/* inst_cycle_ctrl.sv */
// count holds 0 through reset and the first edge after release, then wraps over RV_INST_CYCLES
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module inst_cycle_ctrl (
  input  wire                       clk,
  input  wire                       rst_n_i,
  output rv_core_pkg::inst_cycle_t  cycle_cnt_o
);

  logic                     run_q; // set on the first edge after reset
  rv_core_pkg::inst_cycle_t cnt_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q <= 1'b0;
      cnt_q <= '0;
    end else begin
      run_q <= 1'b1;
      if (!run_q || (cnt_q == `RV_INST_CYCLES - 1)) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + rv_core_pkg::inst_cycle_t'(1);
      end
    end
  end

  assign cycle_cnt_o = cnt_q;

endmodule

`default_nettype wire

/* rv_core_pkg.sv */
// core data types; widths follow rv_params.svh, step count kept 8 bits wide
`default_nettype none

`include "rv_params.svh"

package rv_core_pkg;

  // data word and pc
  typedef logic [`RV_XLEN-1:0] xlen_t;

  // register index
  typedef logic [$clog2(`RV_REG_NUM)-1:0] reg_idx_t;

  // current step of the instruction cycle
  typedef logic [7:0] inst_cycle_t;

endpackage

`default_nettype wire

/* rv_isa_pkg.sv */
// RV64I encodings for the supported subset only; no loads, stores, system or M opcodes
`default_nettype none

package rv_isa_pkg;

  // instruction bits [6:2], bits [1:0] assumed to be 2'b11
  typedef enum logic [4:0] {
    LUI       = 5'b01101,
    AUIPC     = 5'b00101,
    JAL       = 5'b11011,
    JALR      = 5'b11001,
    BRANCH    = 5'b11000,
    OP_IMM    = 5'b00100,
    OP        = 5'b01100,
    OP_IMM_32 = 5'b00110,
    OP_32     = 5'b01110
  } opcode_e;

  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;
  typedef logic [31:0] inst_t;

  // integer groups
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101; // srl / sra
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // branches
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam int F7_ALT_BIT = 5; // sub and arithmetic shift select

endpackage

`default_nettype wire

/* rv_params.svh */
// core constants; pc reset and step numbers assume the fixed six-step, non-overlapped cycle
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data path
`define RV_XLEN 64
`define RV_REG_NUM 32

// first fetch address
`define RV_PC_RESET 64'h0

// instruction cycle
`define RV_INST_CYCLES 6
`define RV_EXE_STEP 4 // write-back step, decode registers one step earlier

`endif
